// File: comp4TwosComp.sv
`timescale 1ns/100ps
`default_nettype none

module comp4TwosComp (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   enable,
   input  maxMetricPkg::candidate in0,
   input  maxMetricPkg::candidate in1,
   input  maxMetricPkg::candidate in2,
   input  maxMetricPkg::candidate in3,
   output maxMetricPkg::candidate winner
);

   maxMetricPkg::candidate best01;
   maxMetricPkg::candidate best23;
   maxMetricPkg::candidate best;

   // inputs arrive in index order, so >= hands ties to the later one
   always_comb begin
      if ($signed(in1.value) >= $signed(in0.value)) begin
         best01 = in1;
      end else begin
         best01 = in0;
      end

      if ($signed(in3.value) >= $signed(in2.value)) begin
         best23 = in3;
      end else begin
         best23 = in2;
      end

      if ($signed(best23.value) >= $signed(best01.value)) begin
         best = best23;  // upper pair wins equal maxima
      end else begin
         best = best01;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         winner <= '0;
      end else if (enable) begin
         winner <= best;  // held while the pipeline stalls
      end
   end

endmodule

`default_nettype wire

// File: maxMetric.f
maxMetricPkg.sv
comp4TwosComp.sv
metricAccumulator.sv
maxMetricTree.sv
maxMetricSearch.sv
maxMetricTb.sv

// File: maxMetricPkg.sv
`default_nettype none

package maxMetricPkg;

   // trellis size and word widths
   localparam int numStates   = 64;
   localparam int indexWidth  = 6;    // log2 of numStates
   localparam int metricWidth = 12;   // signed accumulated metric
   localparam int branchWidth = 8;    // signed branch metric
   localparam int treeDepth   = 3;    // four-way compare stages over 64 states

   // one contender in the compare tree
   typedef struct packed {
      logic [metricWidth-1:0] value;  // two's complement
      logic [indexWidth-1:0]  index;  // global state index
   } candidate;

   // input payload, one per symbol
   typedef struct packed {
      logic                                    clear;   // restart all paths
      logic [numStates-1:0][branchWidth-1:0]   branch;  // branch[s] for state s
   } symbolBeat;

   // output payload, one per accepted symbol
   typedef struct packed {
      logic [indexWidth-1:0]  index;     // surviving state
      logic [metricWidth-1:0] maxValue;  // its metric
   } decision;

endpackage

`default_nettype wire

// File: maxMetricSearch.sv
`timescale 1ns/100ps
`default_nettype none

module maxMetricSearch (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    inValid,
   output logic                    inReady,
   input  maxMetricPkg::symbolBeat inBeat,
   output logic                    outValid,
   input  logic                    outReady,
   output maxMetricPkg::decision   outDecision
);

   logic [maxMetricPkg::numStates-1:0][maxMetricPkg::metricWidth-1:0] metrics;
   logic                                                            metricsValid;

   // path metrics, updated on the accepting edge
   metricAccumulator metricAccumulator_inst (
      .clk          (clk),
      .reset        (reset),
      .inValid      (inValid),
      .enable       (inReady),       // tree advance gates the update
      .inBeat       (inBeat),
      .metrics      (metrics),
      .metricsValid (metricsValid)
   );

   // three stages later the winner pops out
   maxMetricTree maxMetricTree_inst (
      .clk          (clk),
      .reset        (reset),
      .metrics      (metrics),
      .metricsValid (metricsValid),
      .outReady     (outReady),
      .advance      (inReady),       // low only while output is blocked
      .outValid     (outValid),
      .outDecision  (outDecision)
   );

endmodule

`default_nettype wire

// File: maxMetricTb.sv
`timescale 1ns/100ps
`default_nettype none

module maxMetricTb;

   localparam int resetCycles = 16;
   localparam int totalBeats  = 107;  // 1 + 2 + 40 + 16 + 8 + 40 over the six tests
   localparam int stallMargin = 400;  // room for blocked output, random gaps and drains
   localparam int cycleLimit  = totalBeats * (maxMetricPkg::treeDepth + 1)
                                + stallMargin + resetCycles;
   localparam int drainLimit  = 64;
   localparam int maxMetric   = (1 << (maxMetricPkg::metricWidth - 1)) - 1;
   localparam int minMetric   = -(1 << (maxMetricPkg::metricWidth - 1));

   logic                    clk;
   logic                    reset;
   logic                    inValid;
   logic                    inReady;
   maxMetricPkg::symbolBeat inBeat;
   logic                    outValid;
   logic                    outReady;
   maxMetricPkg::decision   outDecision;

   int                      model [maxMetricPkg::numStates];  // reference path metrics
   maxMetricPkg::decision   expQ [$];
   maxMetricPkg::decision   lastTaken;
   int                      takeCycles [$];   // cycle of each output handshake
   int                      cycleCount = 0;
   int                      errorCount = 0;
   int                      passCount = 0;
   int                      failCount = 0;
   logic [31:0]             lfsrState;
   string                   testName;

   maxMetricSearch maxMetricSearch_inst (
      .clk         (clk),
      .reset       (reset),
      .inValid     (inValid),
      .inReady     (inReady),
      .inBeat      (inBeat),
      .outValid    (outValid),
      .outReady    (outReady),
      .outDecision (outDecision)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic lfsrBit();
      logic fb;
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] randomBits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsrBit()};  // one step per bit
      end
      return r;
   endfunction

   function automatic maxMetricPkg::symbolBeat randomBeat(input logic clear);
      maxMetricPkg::symbolBeat beat;
      beat.clear = clear;
      for (int s = 0; s < maxMetricPkg::numStates; s++) begin
         beat.branch[s] = maxMetricPkg::branchWidth'(randomBits(maxMetricPkg::branchWidth));
      end
      return beat;
   endfunction

   // largest metric with the later state winning equal values
   function automatic maxMetricPkg::decision expectedDecision();
      maxMetricPkg::decision d;
      int best;
      int bestIndex;
      best = model[0];
      bestIndex = 0;
      for (int s = 1; s < maxMetricPkg::numStates; s++) begin
         if (model[s] >= best) begin
            best = model[s];
            bestIndex = s;
         end
      end
      d.index    = maxMetricPkg::indexWidth'(bestIndex);
      d.maxValue = maxMetricPkg::metricWidth'(best);
      return d;
   endfunction

   task automatic applyModel(input maxMetricPkg::symbolBeat beat);
      int b;
      int sum;
      for (int s = 0; s < maxMetricPkg::numStates; s++) begin
         b = int'($signed(beat.branch[s]));
         sum = beat.clear ? b : model[s] + b;
         if (sum > maxMetric) sum = maxMetric;
         if (sum < minMetric) sum = minMetric;
         model[s] = sum;
      end
      expQ.push_back(expectedDecision());
   endtask

   task automatic reportFailure(input string what);
      $display("%s: %s", testName, what);
      errorCount++;
   endtask

   task automatic compareDecision(input maxMetricPkg::decision expected,
                                  input maxMetricPkg::decision actual);
      assert (actual == expected) else begin
         $display("Mismatch in %s: expected index %0d value %0d, actual index %0d value %0d",
                  testName, expected.index, $signed(expected.maxValue),
                  actual.index, $signed(actual.maxValue));
         errorCount++;
      end
   endtask

   task automatic expectCount(input int expected, input int actual);
      assert (actual == expected) else begin
         $display("Mismatch in %s: expected %0d decisions, actual %0d",
                  testName, expected, actual);
         errorCount++;
      end
   endtask

   task automatic sendBeat(input maxMetricPkg::symbolBeat beat);
      inValid <= 1'b1;
      inBeat  <= beat;
      do begin
         @(posedge clk);
      end while (!inReady);  // inReady seen before this edge means the edge took it
      applyModel(beat);
   endtask

   task automatic waitDrain();
      int waited;
      waited = 0;
      while (expQ.size() != 0 && waited < drainLimit) begin
         @(posedge clk);
         waited++;
      end
      assert (expQ.size() == 0) else
         reportFailure($sformatf("%0d decisions never arrived", expQ.size()));
   endtask

   task automatic finishTest(input int startErrors);
      if (errorCount == startErrors) begin
         $display("%s: pass", testName);
         passCount++;
      end else begin
         $display("%s: FAIL with %0d errors", testName, errorCount - startErrors);
         failCount++;
      end
   endtask

   task automatic singleBeatTest();
      maxMetricPkg::symbolBeat beat;
      int startErrors;
      testName = "singleBeat";
      startErrors = errorCount;
      assert (!outValid) else reportFailure("outValid high after reset");
      assert (inReady) else reportFailure("inReady low after reset");
      beat.clear = 1'b1;
      for (int s = 0; s < maxMetricPkg::numStates; s++) begin
         beat.branch[s] = maxMetricPkg::branchWidth'(s - 40);
      end
      beat.branch[37] = 8'd100;  // unique peak
      sendBeat(beat);
      inValid <= 1'b0;
      // accepted on edge N and low through edge N+3
      repeat (maxMetricPkg::treeDepth) begin
         @(posedge clk);
         assert (!outValid) else reportFailure("outValid rose before three cycles");
      end
      #1;
      assert (outValid) else reportFailure("outValid not high three cycles after acceptance");
      waitDrain();
      finishTest(startErrors);
   endtask

   task automatic tieTest();
      maxMetricPkg::symbolBeat beat;
      int startErrors;
      testName = "ties";
      startErrors = errorCount;
      beat.clear = 1'b1;
      for (int s = 0; s < maxMetricPkg::numStates; s++) beat.branch[s] = 8'd20;
      sendBeat(beat);  // all equal so state 63 wins
      for (int s = 0; s < maxMetricPkg::numStates; s++) beat.branch[s] = -8'sd10;
      beat.branch[5]  = 8'd90;
      beat.branch[50] = 8'd90;
      sendBeat(beat);
      inValid <= 1'b0;
      waitDrain();
      finishTest(startErrors);
   endtask

   task automatic saturationTest();
      maxMetricPkg::symbolBeat beat;
      maxMetricPkg::decision   want;
      int startErrors;
      testName = "saturation";
      startErrors = errorCount;
      for (int k = 0; k < 20; k++) begin
         beat.clear = (k == 0);
         for (int s = 0; s < maxMetricPkg::numStates; s++) begin
            case (s % 4)
               0:       beat.branch[s] = 8'd127;
               1:       beat.branch[s] = 8'h80;   // -128
               2:       beat.branch[s] = 8'd3;
               default: beat.branch[s] = -8'sd3;
            endcase
         end
         sendBeat(beat);
      end
      inValid <= 1'b0;
      waitDrain();
      want.index = 6'd60;
      want.maxValue = 12'h7ff;  // +2047 on states 0, 4 .. 60
      compareDecision(want, lastTaken);
      for (int k = 0; k < 20; k++) begin
         beat.clear = (k == 0);
         for (int s = 0; s < maxMetricPkg::numStates; s++) beat.branch[s] = 8'h80;
         sendBeat(beat);
      end
      inValid <= 1'b0;
      waitDrain();
      want.index = 6'd63;
      want.maxValue = 12'h800;  // everything pinned at -2048
      compareDecision(want, lastTaken);
      finishTest(startErrors);
   endtask

   task automatic backToBackTest();
      int startErrors;
      testName = "backToBack";
      startErrors = errorCount;
      takeCycles.delete();
      for (int i = 0; i < 16; i++) sendBeat(randomBeat(i == 0));
      inValid <= 1'b0;
      waitDrain();
      expectCount(16, takeCycles.size());
      assert (takeCycles.size() == 16 && takeCycles[15] - takeCycles[0] == 15) else
         reportFailure("decisions did not arrive one per cycle");
      finishTest(startErrors);
   endtask

   task automatic backPressureTest();
      int startErrors;
      testName = "backPressure";
      startErrors = errorCount;
      takeCycles.delete();
      outReady <= 1'b0;
      fork
         begin
            for (int i = 0; i < 8; i++) sendBeat(randomBeat(1'b0));
            inValid <= 1'b0;
         end
         begin
            repeat (12) @(posedge clk);
            assert (!inReady) else reportFailure("inReady stayed high while output blocked");
            outReady <= 1'b1;
         end
      join
      waitDrain();
      expectCount(8, takeCycles.size());
      finishTest(startErrors);
   endtask

   task automatic randomTest();
      maxMetricPkg::symbolBeat beats [40];
      logic sendDone;
      int startErrors;
      testName = "random";
      startErrors = errorCount;
      for (int i = 0; i < 40; i++) beats[i] = randomBeat(i % 8 == 0);
      sendDone = 1'b0;
      fork
         begin
            for (int i = 0; i < 40; i++) sendBeat(beats[i]);
            inValid <= 1'b0;
            sendDone = 1'b1;
         end
         while (!sendDone) begin
            outReady <= (randomBits(2) != 0);  // low one cycle in four
            @(posedge clk);
         end
      join
      outReady <= 1'b1;
      waitDrain();
      finishTest(startErrors);
   endtask

   // cycle limit and output handshake collector
   always @(posedge clk) begin : monitor
      maxMetricPkg::decision expected;
      cycleCount++;
      if (cycleCount > cycleLimit) begin
         $display("timeout after %0d cycles during %s", cycleCount, testName);
         $display("Regression failed");
         $finish;
      end else if (!reset && outValid && outReady) begin
         takeCycles.push_back(cycleCount);
         lastTaken = outDecision;
         assert (expQ.size() != 0) else
            reportFailure("decision arrived with no beat outstanding");
         if (expQ.size() != 0) begin
            expected = expQ.pop_front();
            compareDecision(expected, outDecision);
         end
      end
   end

   initial begin
      lfsrState = 32'he1ce_83ff;
      testName  = "reset";
      reset     = 1'b1;
      inValid   = 1'b0;
      inBeat    = '0;
      outReady  = 1'b1;
      for (int s = 0; s < maxMetricPkg::numStates; s++) model[s] = 0;
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      singleBeatTest();
      tieTest();
      saturationTest();
      backToBackTest();
      backPressureTest();
      randomTest();
      $display("tests passed %0d, failed %0d, failed checks %0d",
               passCount, failCount, errorCount);
      if (errorCount == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: maxMetricTree.sv
`timescale 1ns/100ps
`default_nettype none

module maxMetricTree (
   input  logic                                                     clk,
   input  logic                                                     reset,
   input  logic [maxMetricPkg::numStates-1:0][maxMetricPkg::metricWidth-1:0] metrics,
   input  logic                                                     metricsValid,
   input  logic                                                     outReady,
   output logic                                                     advance,
   output logic                                                     outValid,
   output maxMetricPkg::decision                                    outDecision
);

   localparam int stage1Count = maxMetricPkg::numStates / 4;   // 16
   localparam int stage2Count = maxMetricPkg::numStates / 16;  // 4

   maxMetricPkg::candidate [maxMetricPkg::numStates-1:0] leaf;
   maxMetricPkg::candidate [stage1Count-1:0]             stage1;
   maxMetricPkg::candidate [stage2Count-1:0]             stage2;
   maxMetricPkg::candidate                               stage3;
   logic [maxMetricPkg::treeDepth-1:0]                   validPipe;

   // single stall point, freezes every stage together
   assign advance = !outValid || outReady;

   // each metric travels with its own state number
   for (genvar s = 0; s < maxMetricPkg::numStates; s++) begin : tagGen
      assign leaf[s].value = metrics[s];
      assign leaf[s].index = maxMetricPkg::indexWidth'(s);
   end

   for (genvar g = 0; g < stage1Count; g++) begin : stage1Gen
      comp4TwosComp comp4TwosComp_inst (
         .clk    (clk),
         .reset  (reset),
         .enable (advance),
         .in0    (leaf[4*g]),
         .in1    (leaf[4*g+1]),
         .in2    (leaf[4*g+2]),
         .in3    (leaf[4*g+3]),
         .winner (stage1[g])
      );
   end

   // groups of 16 states
   for (genvar g = 0; g < stage2Count; g++) begin : stage2Gen
      comp4TwosComp comp4TwosComp_inst (
         .clk    (clk),
         .reset  (reset),
         .enable (advance),
         .in0    (stage1[4*g]),
         .in1    (stage1[4*g+1]),
         .in2    (stage1[4*g+2]),
         .in3    (stage1[4*g+3]),
         .winner (stage2[g])
      );
   end

   // final compare across all 64
   comp4TwosComp stage3_inst (
      .clk    (clk),
      .reset  (reset),
      .enable (advance),
      .in0    (stage2[0]),
      .in1    (stage2[1]),
      .in2    (stage2[2]),
      .in3    (stage2[3]),
      .winner (stage3)
   );

   // valid rides alongside the candidates, one bit per stage
   always_ff @(posedge clk) begin
      if (reset) begin
         validPipe <= '0;
      end else if (advance) begin
         validPipe <= {validPipe[maxMetricPkg::treeDepth-2:0], metricsValid};
      end
   end

   assign outValid = validPipe[maxMetricPkg::treeDepth-1];

   assign outDecision.index    = stage3.index;
   assign outDecision.maxValue = stage3.value;

endmodule

`default_nettype wire

// File: metricAccumulator.sv
`timescale 1ns/100ps
`default_nettype none

module metricAccumulator (
   input  logic                                                     clk,
   input  logic                                                     reset,
   input  logic                                                     inValid,
   input  logic                                                     enable,
   input  maxMetricPkg::symbolBeat                                  inBeat,
   output logic [maxMetricPkg::numStates-1:0][maxMetricPkg::metricWidth-1:0] metrics,
   output logic                                                     metricsValid
);

   logic [maxMetricPkg::numStates-1:0][maxMetricPkg::metricWidth-1:0] nextMetrics;

   // load or saturating add for one path
   function automatic logic [maxMetricPkg::metricWidth-1:0] updateMetric(
      input logic [maxMetricPkg::metricWidth-1:0] acc,
      input logic [maxMetricPkg::branchWidth-1:0] branch,
      input logic                                 clear
   );
      logic [maxMetricPkg::metricWidth-1:0] branchExt;
      logic [maxMetricPkg::metricWidth:0]   sum;      // one guard bit
      logic [maxMetricPkg::metricWidth-1:0] result;

      branchExt = {{(maxMetricPkg::metricWidth - maxMetricPkg::branchWidth)
                    {branch[maxMetricPkg::branchWidth-1]}}, branch};
      sum = {acc[maxMetricPkg::metricWidth-1], acc} +
            {branchExt[maxMetricPkg::metricWidth-1], branchExt};

      if (clear) begin
         result = branchExt;
      end else if (sum[maxMetricPkg::metricWidth] != sum[maxMetricPkg::metricWidth-1]) begin
         // overflow, guard bit carries the true sign
         if (sum[maxMetricPkg::metricWidth]) begin
            result = {1'b1, {(maxMetricPkg::metricWidth-1){1'b0}}};  // -2048
         end else begin
            result = {1'b0, {(maxMetricPkg::metricWidth-1){1'b1}}};  // +2047
         end
      end else begin
         result = sum[maxMetricPkg::metricWidth-1:0];
      end
      return result;
   endfunction

   always_comb begin
      for (int s = 0; s < maxMetricPkg::numStates; s++) begin
         nextMetrics[s] = updateMetric(metrics[s], inBeat.branch[s], inBeat.clear);
      end
   end

   // enable low means the tree is stalled, everything holds
   always_ff @(posedge clk) begin
      if (reset) begin
         metrics      <= '0;
         metricsValid <= 1'b0;
      end else if (enable) begin
         metricsValid <= inValid;      // marks a fresh set for the tree
         if (inValid) begin
            metrics <= nextMetrics;
         end
      end
   end

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# build and run the regression with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module maxMetricTb -f maxMetric.f -o maxMetricSim \
   && ./obj_dir/maxMetricSim | tee sim.log \
   || { echo "build or run error"; exit 1; }
test -s sim.log || { echo "no simulation log"; exit 1; }
grep -q "Regression failed" sim.log && exit 1 || exit 0
